//--- sm83_defines.svh
`ifndef SM83_DEFINES_SVH
`define SM83_DEFINES_SVH

`define SM83_ADDR_W 16
`define SM83_DATA_W 8
`define SM83_STEP_W 3

`define SM83_RESET_PC 16'h0000
`define SM83_OP_NOP 8'h00

`endif

//--- sm83_isa_pkg.sv
`default_nettype none

package sm83_isa_pkg;

    typedef struct packed {
        logic [1:0] x;                  // Block
        logic [2:0] y;                  // Destination or ALU op
        logic [2:0] z;                  // Source
    } op_xyz_t;

    typedef struct packed {
        logic [1:0] x;
        logic [1:0] p;                  // Register pair
        logic       q;
        logic [2:0] z;
    } op_xpqz_t;

    typedef union packed {
        op_xyz_t  xyz;
        op_xpqz_t xpqz;
    } opcode_u;

    typedef enum logic [3:0] {
        NONE, Z, W, B, C, D, E, H, L, PCH, PCL, A, MEM
    } reg8_t;

    typedef enum logic [2:0] {WZ, BC, DE, HL, PC} reg16_t;

    typedef enum logic [1:0] {COND_NZ, COND_Z, COND_NC, COND_C} cond_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_AND, ALU_XOR, ALU_OR, ALU_CP
    } alu_op_t;

    typedef struct packed {
        logic z;
        logic n;
        logic h;
        logic c;
    } flags_t;

endpackage

`default_nettype wire

//--- sm83_uop_pkg.sv
`default_nettype none

package sm83_uop_pkg;

    // Accumulator input of the ALU
    typedef enum logic [1:0] {ACC_A, ACC_DB, ACC_PCL} s_acc_t;

    // Second ALU operand
    typedef enum logic {ARG_DB, ARG_ONE} s_arg_t;

    // Source of the 8-bit writeback
    typedef enum logic {R_WB_DB, R_WB_ALU} s_r_wb_t;

    // Source of the 16-bit writeback
    typedef enum logic [1:0] {RR_WB_NONE, RR_WB_IDU, RR_WB_WZ} s_rr_wb_t;

    typedef enum logic [1:0] {INC, DEC, ADJ, HOLD} idu_mode_t;

endpackage

`default_nettype wire

//--- sm83_ifs.sv
`timescale 1ns/1ns
`default_nettype none
`include "sm83_defines.svh"

interface uop_if
    import sm83_isa_pkg::*, sm83_uop_pkg::*;
();
    reg16_t    s_ab;                    // Address bus source
    reg8_t     s_db;                    // Data bus source
    reg8_t     t_db;                    // Data bus target
    s_r_wb_t   s_r_wb;
    alu_op_t   alu_op;
    s_acc_t    s_acc;
    s_arg_t    s_arg;
    idu_mode_t idu;
    s_rr_wb_t  s_rr_wb;
    reg16_t    t_rr_wb;
    logic      wr_pc;                   // PC takes the IDU output

    modport dec (output s_ab, s_db, t_db, s_r_wb, alu_op, s_acc, s_arg,
                 output idu, s_rr_wb, t_rr_wb, wr_pc);
    modport dp  (input s_ab, s_db, t_db, s_r_wb, alu_op, s_acc, s_arg,
                 input idu, s_rr_wb, t_rr_wb, wr_pc);
endinterface

interface alu_if
    import sm83_isa_pkg::*;
();
    logic [`SM83_DATA_W-1:0] acc;
    logic [`SM83_DATA_W-1:0] arg;
    alu_op_t                 op;
    flags_t                  flags_in;
    logic [`SM83_DATA_W-1:0] result;
    flags_t                  flags_out;

    modport dp  (output acc, arg, op, flags_in, input result, flags_out);
    modport alu (input acc, arg, op, flags_in, output result, flags_out);
endinterface

interface seq_if
    import sm83_isa_pkg::*;
();
    logic                    done;      // Last step, IR takes the fetched byte
    logic                    is_cond;
    logic [`SM83_STEP_W-1:0] next_cond; // Step taken when the condition fails
    cond_t                   cond;

    modport dec (output done, is_cond, next_cond, cond);
    modport seq (input done, is_cond, next_cond, cond);
endinterface

`default_nettype wire

//--- sm83_alu.sv
`timescale 1ns/1ns
`default_nettype none
`include "sm83_defines.svh"

module sm83_alu
    import sm83_isa_pkg::*;
(
    alu_if.alu alu
);
    logic                    sub;
    logic                    cin;
    logic [`SM83_DATA_W:0]   full;      // Top bit is carry or borrow out of bit 7
    logic [4:0]              half;      // Top bit is carry or borrow out of bit 3

    always_comb begin
        sub = alu.op inside {ALU_SUB, ALU_SBC, ALU_CP};
        cin = (alu.op == ALU_ADC || alu.op == ALU_SBC) && alu.flags_in.c;
        if (sub) begin
            full = {1'b0, alu.acc} - {1'b0, alu.arg} - {8'd0, cin};
            half = {1'b0, alu.acc[3:0]} - {1'b0, alu.arg[3:0]} - {4'd0, cin};
        end else begin
            full = {1'b0, alu.acc} + {1'b0, alu.arg} + {8'd0, cin};
            half = {1'b0, alu.acc[3:0]} + {1'b0, alu.arg[3:0]} + {4'd0, cin};
        end
        alu.flags_out.n = sub;
        alu.flags_out.h = half[4];
        alu.flags_out.c = full[8];
        case (alu.op)
            ALU_AND: alu.result = alu.acc & alu.arg;
            ALU_XOR: alu.result = alu.acc ^ alu.arg;
            ALU_OR:  alu.result = alu.acc | alu.arg;
            default: alu.result = full[7:0];
        endcase
        if (alu.op inside {ALU_AND, ALU_XOR, ALU_OR}) begin
            alu.flags_out.h = (alu.op == ALU_AND);  // Only AND sets H
            alu.flags_out.c = 1'b0;
        end
        alu.flags_out.z = (alu.result == '0);
    end
endmodule

`default_nettype wire

//--- sm83_sequencer.sv
`timescale 1ns/1ns
`default_nettype none
`include "sm83_defines.svh"

module sm83_sequencer
    import sm83_isa_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    step_ack,
    input  flags_t                  flags,
    input  logic [`SM83_DATA_W-1:0] fetched,
    seq_if.seq                      seq,
    output opcode_u                 ir,
    output logic [`SM83_STEP_W-1:0] step
);
    logic cond_met;

    always_comb begin
        case (seq.cond)
            COND_NZ: cond_met = !flags.z;
            COND_Z:  cond_met = flags.z;
            COND_NC: cond_met = !flags.c;
            default: cond_met = flags.c;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ir   <= opcode_u'(`SM83_OP_NOP);  // First step fetches at the reset PC
            step <= '0;
        end else if (step_ack) begin
            if (seq.done) begin
                ir   <= opcode_u'(fetched);
                step <= '0;
            end else if (seq.is_cond && !cond_met) begin
                step <= seq.next_cond;
            end else begin
                step <= step + 1'b1;
            end
        end
    end
endmodule

`default_nettype wire

//--- sm83_decoder.sv
`timescale 1ns/1ns
`default_nettype none
`include "sm83_defines.svh"

module sm83_decoder
    import sm83_isa_pkg::*, sm83_uop_pkg::*;
(
    input  opcode_u                 ir,
    input  logic [`SM83_STEP_W-1:0] step,
    uop_if.dec                      uop,
    seq_if.dec                      seq
);
    localparam logic [`SM83_STEP_W-1:0] JR_FETCH_STEP = 3;

    logic [1:0] x;
    logic [2:0] y;
    logic [2:0] z;
    logic [1:0] p;
    logic       q;
    logic       rd_z;                   // Step reads an operand byte into Z
    logic       at_hl;                  // Operand address is HL instead of PC

    function automatic reg8_t r8_of(input logic [2:0] f);
        case (f)
            3'd0:    return B;
            3'd1:    return C;
            3'd2:    return D;
            3'd3:    return E;
            3'd4:    return H;
            3'd5:    return L;
            3'd6:    return MEM;
            default: return A;
        endcase
    endfunction

    function automatic reg16_t r16_of(input logic [1:0] f);
        case (f)
            2'd0:    return BC;
            2'd1:    return DE;
            default: return HL;
        endcase
    endfunction

    assign x = ir.xyz.x;
    assign y = ir.xyz.y;
    assign z = ir.xyz.z;
    assign p = ir.xpqz.p;
    assign q = ir.xpqz.q;

    always_comb begin
        // Every step starts out as the opcode fetch at PC
        seq.done      = 1'b1;
        seq.is_cond   = 1'b0;
        seq.next_cond = JR_FETCH_STEP;
        seq.cond      = cond_t'(y[1:0]);
        uop.s_ab      = PC;
        uop.s_db      = NONE;
        uop.t_db      = NONE;
        uop.s_r_wb    = R_WB_DB;
        uop.alu_op    = alu_op_t'(y);
        uop.s_acc     = ACC_A;
        uop.s_arg     = ARG_DB;
        uop.idu       = INC;
        uop.s_rr_wb   = RR_WB_NONE;
        uop.t_rr_wb   = WZ;
        uop.wr_pc     = 1'b1;
        rd_z          = 1'b0;
        at_hl         = 1'b0;
        case (x)
            2'd0: begin
                if (z == 3'd0 && (y == 3'd3 || y[2])) begin     // JR e, JR cc,e
                    case (step)
                        3'd0: begin
                            rd_z        = 1'b1;
                            seq.is_cond = y[2];
                        end
                        3'd1: begin                             // WZ takes PC + e
                            seq.done    = 1'b0;
                            uop.wr_pc   = 1'b0;
                            uop.idu     = ADJ;
                            uop.s_db    = Z;
                            uop.t_db    = Z;
                            uop.s_r_wb  = R_WB_ALU;
                            uop.alu_op  = ALU_ADD;
                            uop.s_acc   = ACC_PCL;
                            uop.s_rr_wb = RR_WB_IDU;
                        end
                        3'd2:    uop.s_ab = WZ;
                        default: ;
                    endcase
                end else if (z == 3'd1 && !q && p != 2'd3) begin // LD rr,nn
                    case (step)
                        3'd0: rd_z = 1'b1;
                        3'd1: begin
                            seq.done = 1'b0;
                            uop.s_db = MEM;
                            uop.t_db = W;
                        end
                        default: begin
                            uop.s_rr_wb = RR_WB_WZ;
                            uop.t_rr_wb = r16_of(p);
                        end
                    endcase
                end else if (z[2:1] == 2'b10 && y != 3'd6) begin // INC r, DEC r
                    uop.s_db   = r8_of(y);
                    uop.t_db   = r8_of(y);
                    uop.s_r_wb = R_WB_ALU;
                    uop.alu_op = z[0] ? ALU_SUB : ALU_ADD;
                    uop.s_acc  = ACC_DB;
                    uop.s_arg  = ARG_ONE;
                end else if (z == 3'd6 && y != 3'd6) begin      // LD r,n
                    if (step == 3'd0) begin
                        rd_z = 1'b1;
                    end else begin
                        uop.s_db = Z;
                        uop.t_db = r8_of(y);
                    end
                end
            end
            2'd1: begin
                if (z == 3'd6 && y != 3'd6) begin               // LD r,(HL)
                    if (step == 3'd0) begin
                        rd_z  = 1'b1;
                        at_hl = 1'b1;
                    end else begin
                        uop.s_db = Z;
                        uop.t_db = r8_of(y);
                    end
                end else if (y == 3'd6 && z != 3'd6) begin      // LD (HL),r
                    if (step == 3'd0) begin
                        seq.done  = 1'b0;
                        uop.wr_pc = 1'b0;
                        uop.s_ab  = HL;
                        uop.s_db  = r8_of(z);
                        uop.t_db  = MEM;
                    end
                end else if (y != 3'd6) begin                   // LD r,r'
                    uop.s_db = r8_of(z);
                    uop.t_db = r8_of(y);
                end
            end
            default: begin
                if (x == 2'd2 || z == 3'd6) begin               // ALU A,r / (HL) / n
                    if (z == 3'd6 && step == 3'd0) begin
                        rd_z  = 1'b1;
                        at_hl = (x == 2'd2);
                    end else begin
                        uop.s_db   = (z == 3'd6) ? Z : r8_of(z);
                        uop.t_db   = (alu_op_t'(y) == ALU_CP) ? NONE : A;
                        uop.s_r_wb = R_WB_ALU;
                    end
                end
            end
        endcase
        if (rd_z) begin
            seq.done = 1'b0;
            uop.s_db = MEM;
            uop.t_db = Z;
            if (at_hl) begin
                uop.s_ab  = HL;
                uop.wr_pc = 1'b0;
            end
        end
    end
endmodule

`default_nettype wire

//--- sm83_datapath.sv
`timescale 1ns/1ns
`default_nettype none
`include "sm83_defines.svh"

module sm83_datapath
    import sm83_isa_pkg::*, sm83_uop_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    uop_if.dp                       uop,
    alu_if.dp                       alu,
    output logic                    step_ack,
    output flags_t                  flags,
    output logic [`SM83_DATA_W-1:0] fetched,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output logic [`SM83_ADDR_W-1:0] wb_adr,
    output logic [`SM83_DATA_W-1:0] wb_dat_o,
    input  logic [`SM83_DATA_W-1:0] wb_dat_i,
    input  logic                    wb_ack
);
    logic [`SM83_DATA_W-1:0] a, b, c, d, e, h, l;
    logic [`SM83_DATA_W-1:0] z, w;      // Temporaries
    logic [`SM83_ADDR_W-1:0] pc;
    logic                    active;    // Transfer open, set once out of reset
    logic [`SM83_DATA_W-1:0] db;
    logic [`SM83_DATA_W-1:0] r_data;
    logic [`SM83_ADDR_W-1:0] ab;
    logic [`SM83_ADDR_W-1:0] idu_out;
    logic [`SM83_ADDR_W-1:0] rr_data;

    always_comb begin
        case (uop.s_db)
            Z:       db = z;
            W:       db = w;
            B:       db = b;
            C:       db = c;
            D:       db = d;
            E:       db = e;
            H:       db = h;
            L:       db = l;
            PCH:     db = pc[15:8];
            PCL:     db = pc[7:0];
            A:       db = a;
            MEM:     db = wb_dat_i;
            default: db = '0;
        endcase
        case (uop.s_ab)
            BC:      ab = {b, c};
            DE:      ab = {d, e};
            HL:      ab = {h, l};
            WZ:      ab = {w, z};
            default: ab = pc;
        endcase
        case (uop.idu)
            INC:     idu_out = ab + 16'd1;
            DEC:     idu_out = ab - 16'd1;
            ADJ:     idu_out = {ab[15:8] + {8{db[7]}} + {7'd0, alu.flags_out.c}, ab[7:0]};
            default: idu_out = ab;
        endcase
        case (uop.s_acc)
            ACC_DB:  alu.acc = db;
            ACC_PCL: alu.acc = pc[7:0];
            default: alu.acc = a;
        endcase
    end

    assign alu.arg      = (uop.s_arg == ARG_ONE) ? 8'd1 : db;
    assign alu.op       = uop.alu_op;
    assign alu.flags_in = flags;
    assign r_data       = (uop.s_r_wb == R_WB_ALU) ? alu.result : db;
    assign rr_data      = (uop.s_rr_wb == RR_WB_WZ) ? {w, z} : idu_out;

    assign wb_cyc   = active;
    assign wb_stb   = active;
    assign wb_we    = active && (uop.t_db == MEM);
    assign wb_adr   = ab;
    assign wb_dat_o = db;
    assign step_ack = wb_stb && wb_ack;
    assign fetched  = wb_dat_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            pc     <= `SM83_RESET_PC;
            flags  <= '0;
            {a, b, c, d, e, h, l} <= '0;
        end else begin
            active <= 1'b1;
            if (step_ack) begin
                if (uop.s_rr_wb != RR_WB_NONE) begin
                    case (uop.t_rr_wb)
                        BC:      {b, c} <= rr_data;
                        DE:      {d, e} <= rr_data;
                        HL:      {h, l} <= rr_data;
                        WZ:      {w, z} <= rr_data;
                        default: pc <= rr_data;
                    endcase
                end
                if (uop.wr_pc) begin
                    pc <= idu_out;
                end
                case (uop.t_db)             // Z from the ALU overrides the WZ write of JR
                    Z:       z <= r_data;
                    W:       w <= r_data;
                    B:       b <= r_data;
                    C:       c <= r_data;
                    D:       d <= r_data;
                    E:       e <= r_data;
                    H:       h <= r_data;
                    L:       l <= r_data;
                    PCH:     pc[15:8] <= r_data;
                    PCL:     pc[7:0] <= r_data;
                    A:       a <= r_data;
                    default: ;
                endcase
                if (uop.s_r_wb == R_WB_ALU && uop.s_acc != ACC_PCL) begin
                    flags <= alu.flags_out;     // JR offset add leaves flags alone
                    if (uop.s_arg == ARG_ONE) begin
                        flags.c <= flags.c;     // INC and DEC keep the carry
                    end
                end
            end
        end
    end
endmodule

`default_nettype wire

//--- sm83_core.sv
`timescale 1ns/1ns
`default_nettype none
`include "sm83_defines.svh"

module sm83_core
    import sm83_isa_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output logic [`SM83_ADDR_W-1:0] wb_adr,
    output logic [`SM83_DATA_W-1:0] wb_dat_o,
    input  logic [`SM83_DATA_W-1:0] wb_dat_i,
    input  logic                    wb_ack
);
    logic                    step_ack;
    flags_t                  flags;
    logic [`SM83_DATA_W-1:0] fetched;   // Next opcode from the overlapped fetch
    opcode_u                 ir;
    logic [`SM83_STEP_W-1:0] step;

    uop_if uop_bus ();
    seq_if seq_bus ();
    alu_if alu_bus ();

    sm83_sequencer i_sequencer (
        .clk      (clk),
        .rst      (rst),
        .step_ack (step_ack),
        .flags    (flags),
        .fetched  (fetched),
        .seq      (seq_bus),
        .ir       (ir),
        .step     (step)
    );

    sm83_decoder i_decoder (
        .ir   (ir),
        .step (step),
        .uop  (uop_bus),
        .seq  (seq_bus)
    );

    sm83_datapath i_datapath (
        .clk      (clk),
        .rst      (rst),
        .uop      (uop_bus),
        .alu      (alu_bus),
        .step_ack (step_ack),
        .flags    (flags),
        .fetched  (fetched),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_o (wb_dat_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack)
    );

    sm83_alu i_alu (
        .alu (alu_bus)
    );
endmodule

`default_nettype wire

//--- sm83_assertions.sv
`timescale 1ns/1ns
`default_nettype none
`include "sm83_defines.svh"

module sm83_assertions (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`SM83_ADDR_W-1:0] wb_adr,
    input  logic [`SM83_DATA_W-1:0] wb_dat_o,
    input  logic                    wb_ack
);
    int fail_count = 0;                 // Number of failed assertions

    stb_within_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else begin
            $error("wb_stb high while wb_cyc is low");
            fail_count++;
        end

    // Read data on wb_dat_o may follow the bus, so only writes hold it
    request_stable: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we)
                                 && (!wb_we || $stable(wb_dat_o))))
        else begin
            $error("Wishbone request changed before wb_ack");
            fail_count++;
        end

    idle_in_reset: assert property (@(posedge clk) rst |=> (!wb_cyc && !wb_stb && !wb_we))
        else begin
            $error("Wishbone master active during reset");
            fail_count++;
        end
endmodule

`default_nettype wire

//--- tb_sm83_core.sv
`timescale 1ns/1ns
`default_nettype none
`include "sm83_defines.svh"

module tb_sm83_core;
    localparam int NUM_XFERS    = 3000;
    localparam int XFER_TIMEOUT = 20;   // Cycles; a transfer needs at most five
    localparam int RESET_CYCLES = 8;

    logic                    clk;
    logic                    rst;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [`SM83_ADDR_W-1:0] wb_adr;
    logic [`SM83_DATA_W-1:0] wb_dat_o;
    logic [`SM83_DATA_W-1:0] wb_dat_i;
    logic                    wb_ack;

    logic [7:0]  mem [0:65535];         // Slave memory
    logic [7:0]  ref_mem [0:65535];     // Model copy
    integer      seed;
    logic [1:0]  wait_left;
    logic [24:0] exp_q [$];             // Expected {we, adr, data} per transfer

    logic [7:0]  m_r [0:7];             // Register file indexed by the r field
    logic [15:0] m_pc;
    logic [7:0]  m_op;                  // Opcode that runs next
    logic        f_z;
    logic        f_n;
    logic        f_h;
    logic        f_c;

    int error_count;
    int xfer_count;
    int instr_count;
    bit first_seen;

    sm83_core i_sm83_core (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_o (wb_dat_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack)
    );

    bind sm83_core sm83_assertions i_assertions (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic bit cond_holds(input logic [1:0] cc);
        case (cc)
            2'd0:    return !f_z;       // NZ
            2'd1:    return f_z;
            2'd2:    return !f_c;       // NC
            default: return f_c;
        endcase
    endfunction

    // SM83 flag rules, op order ADD ADC SUB SBC AND XOR OR CP
    task automatic alu_model(input logic [2:0] op, input logic [7:0] a,
                             input logic [7:0] b, output logic [7:0] res);
        int cin;
        int sum;
        cin = (op == 3'd1 || op == 3'd3) ? int'(f_c) : 0;
        case (op)
            3'd0, 3'd1: begin
                sum = a + b + cin;
                res = sum[7:0];
                f_n = 1'b0;
                f_h = ((a & 8'h0f) + (b & 8'h0f) + cin) > 15;
                f_c = sum > 255;
            end
            3'd4: begin
                res = a & b;
                f_n = 1'b0;
                f_h = 1'b1;
                f_c = 1'b0;
            end
            3'd5, 3'd6: begin
                res = (op == 3'd5) ? (a ^ b) : (a | b);
                f_n = 1'b0;
                f_h = 1'b0;
                f_c = 1'b0;
            end
            default: begin              // SUB, SBC, CP
                res = a - b - cin;
                f_n = 1'b1;
                f_h = (a & 8'h0f) < ((b & 8'h0f) + cin);
                f_c = a < (b + cin);
            end
        endcase
        f_z = (res == 8'h00);
    endtask

    task automatic bus_read(input logic [15:0] adr, output logic [7:0] data);
        exp_q.push_back({1'b0, adr, 8'h00});
        data = ref_mem[adr];
    endtask

    task automatic bus_write(input logic [15:0] adr, input logic [7:0] data);
        exp_q.push_back({1'b1, adr, data});
        if (adr >= 16'h8000) begin
            ref_mem[adr] = data;        // Lower half is ROM
        end
    endtask

    // Queues the transfers of the opcode in m_op, ending with the next fetch
    task automatic run_instruction();
        logic [1:0] x;
        logic [2:0] y;
        logic [2:0] z;
        logic [7:0] v;
        logic [7:0] hi;
        logic [7:0] res;
        logic       keep_c;
        x = m_op[7:6];
        y = m_op[5:3];
        z = m_op[2:0];
        instr_count++;
        if (x == 2'd0 && z == 3'd0 && (y == 3'd3 || y[2])) begin       // JR e, JR cc,e
            bus_read(m_pc, v);
            m_pc = m_pc + 16'd1;
            if (y == 3'd3 || cond_holds(y[1:0])) begin
                bus_read(m_pc, hi);     // Dummy read
                m_pc = m_pc + {{8{v[7]}}, v};
            end
        end else if (x == 2'd0 && z == 3'd1 && !y[0] && y[2:1] != 2'd3) begin  // LD rr,nn
            bus_read(m_pc, v);
            m_pc = m_pc + 16'd1;
            bus_read(m_pc, hi);
            m_pc = m_pc + 16'd1;
            m_r[{y[2:1], 1'b0}] = hi;
            m_r[{y[2:1], 1'b1}] = v;
        end else if (x == 2'd0 && z[2:1] == 2'b10 && y != 3'd6) begin  // INC r, DEC r
            keep_c = f_c;
            alu_model(z[0] ? 3'd2 : 3'd0, m_r[y], 8'd1, res);
            f_c    = keep_c;
            m_r[y] = res;
        end else if (x == 2'd0 && z == 3'd6 && y != 3'd6) begin        // LD r,n
            bus_read(m_pc, v);
            m_pc   = m_pc + 16'd1;
            m_r[y] = v;
        end else if (x == 2'd1 && z == 3'd6 && y != 3'd6) begin        // LD r,(HL)
            bus_read({m_r[4], m_r[5]}, v);
            m_r[y] = v;
        end else if (x == 2'd1 && y == 3'd6 && z != 3'd6) begin        // LD (HL),r
            bus_write({m_r[4], m_r[5]}, m_r[z]);
        end else if (x == 2'd1 && y != 3'd6) begin
            m_r[y] = m_r[z];
        end else if (x == 2'd2 || (x == 2'd3 && z == 3'd6)) begin      // ALU forms
            if (z != 3'd6) begin
                v = m_r[z];
            end else if (x == 2'd2) begin
                bus_read({m_r[4], m_r[5]}, v);
            end else begin
                bus_read(m_pc, v);
                m_pc = m_pc + 16'd1;
            end
            alu_model(y, m_r[7], v, res);
            if (y != 3'd7) begin
                m_r[7] = res;
            end
        end
        bus_read(m_pc, m_op);           // Fetch of the next opcode
        m_pc = m_pc + 16'd1;
    endtask

    // Memory slave with 0 to 3 wait states
    always @(posedge clk) begin : slave
        logic [31:0] rnd;
        if (rst) begin
            wb_ack    <= 1'b0;
            wait_left <= 2'd0;
        end else if (wb_stb && wb_ack) begin
            wb_ack <= 1'b0;
            if (wb_we && wb_adr >= 16'h8000) begin
                mem[wb_adr] <= wb_dat_o;
            end
            rnd = $random(seed);
            wait_left <= rnd[1:0];
        end else if (wb_cyc && wb_stb) begin
            if (wait_left == 2'd0) begin
                wb_ack   <= 1'b1;
                wb_dat_i <= mem[wb_adr];
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

    always @(posedge clk) begin : monitor
        logic [24:0] expected;
        if (!rst && wb_stb && wb_ack) begin
            if (!first_seen && (wb_we !== 1'b0 || wb_adr !== `SM83_RESET_PC)) begin
                $display("Error: first_fetch expected we=0 adr=%h actual we=%b adr=%h",
                         `SM83_RESET_PC, wb_we, wb_adr);
                error_count++;
            end
            first_seen = 1'b1;
            if (exp_q.size() == 0) begin
                run_instruction();
            end
            expected = exp_q.pop_front();
            if (wb_adr !== expected[23:8]) begin
                $display("Error: transfer_address at transfer %0d expected %h actual %h",
                         xfer_count, expected[23:8], wb_adr);
                error_count++;
            end
            if (wb_we !== expected[24]) begin
                $display("Error: write_enable at transfer %0d expected %b actual %b",
                         xfer_count, expected[24], wb_we);
                error_count++;
            end
            if (expected[24] && wb_dat_o !== expected[7:0]) begin
                $display("Error: write_data at transfer %0d expected %h actual %h",
                         xfer_count, expected[7:0], wb_dat_o);
                error_count++;
            end
            xfer_count <= xfer_count + 1;
        end
    end

    initial begin : main
        logic [31:0] rnd;
        int          last_count;
        int          wait_cycles;
        bit          timed_out;
        rst         = 1'b1;
        wb_ack      = 1'b0;
        wb_dat_i    = '0;
        seed        = 32'h38c2;
        error_count = 0;
        xfer_count  = 0;
        instr_count = 0;
        first_seen  = 1'b0;
        timed_out   = 1'b0;
        m_pc        = `SM83_RESET_PC;
        m_op        = `SM83_OP_NOP;     // Reset opcode runs as a plain fetch
        {f_z, f_n, f_h, f_c} = 4'b0000;
        for (int i = 0; i < 8; i++) begin
            m_r[i] = 8'h00;
        end
        for (int a = 0; a < 65536; a++) begin
            rnd = $random(seed);
            if (a < 32'h8000) begin
                mem[a] = rnd[7:0];
            end else begin
                mem[a] = a[15:8] ^ a[7:0] ^ 8'ha5;
            end
            ref_mem[a] = mem[a];
        end

        @(posedge clk);
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            if (wb_cyc !== 1'b0 || wb_stb !== 1'b0 || wb_we !== 1'b0) begin
                $display("Error: reset_idle expected cyc=0 stb=0 we=0 actual cyc=%b stb=%b we=%b",
                         wb_cyc, wb_stb, wb_we);
                error_count++;
            end
            @(posedge clk);
        end
        rst <= 1'b0;

        while (xfer_count < NUM_XFERS && !timed_out) begin
            last_count  = xfer_count;
            wait_cycles = 0;
            while (xfer_count == last_count && wait_cycles < XFER_TIMEOUT) begin
                @(negedge clk);
                wait_cycles++;
            end
            if (xfer_count == last_count) begin
                timed_out = 1'b1;
                $display("Error: no bus transfer completed within %0d cycles", XFER_TIMEOUT);
                error_count++;
            end
        end

        error_count += i_sm83_core.i_assertions.fail_count;
        $display("Summary: %0d transfers, %0d instructions, %0d errors",
                 xfer_count, instr_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end
endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
sm83_isa_pkg.sv
sm83_uop_pkg.sv
sm83_ifs.sv
sm83_alu.sv
sm83_sequencer.sv
sm83_decoder.sv
sm83_datapath.sv
sm83_core.sv
sm83_assertions.sv
tb_sm83_core.sv

//--- Bender.yml
package:
  name: sm83_core

sources:
  - include_dirs:
      - .
    files:
      - sm83_isa_pkg.sv
      - sm83_uop_pkg.sv
      - sm83_ifs.sv
      - sm83_alu.sv
      - sm83_sequencer.sv
      - sm83_decoder.sv
      - sm83_datapath.sv
      - sm83_core.sv
      - target: test
        files:
          - sm83_assertions.sv
          - tb_sm83_core.sv
